// ==== riscv_core.f ====
+incdir+include
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_stage.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/riscv_core.sv
tb/tb_riscv_core.sv

// ==== tb/tb_riscv_core.sv ====
// directed testbench for the pipelined core, models both memories and checks every store
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module tb_riscv_core;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int    NUM_TESTS       = 6;
    localparam int    CYCLES_PER_TEST = 200;
    localparam int    TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST;
    localparam int    MEM_WORDS       = 64;            // 256 bytes each for code and data
    localparam word_t ECALL           = 32'h0000_0073;

    logic      clk;
    logic      arst_n;
    word_t     instr_addr;
    word_t     instr;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;
    logic      halted;

    word_t     imem [MEM_WORDS];
    word_t     dmem [MEM_WORDS];
    dmem_req_t pending;          // strobe seen mid cycle, committed at the next rising edge
    dmem_req_t store_log [$];    // every store in program order
    dmem_req_t expect_q  [$];

    logic [31:0] lfsr;
    int          prog_len;       // words emitted so far
    int          cycle_cnt;
    int          errors;
    int          test_errs;
    int          tests_passed;
    int          tests_failed;

    riscv_core riscv_core_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr_addr (instr_addr),
        .instr      (instr),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .halted     (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // watchdog over the whole run
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the core did not halt within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // ==============================
    // memory models
    // ==============================
    assign instr      = (instr_addr < MEM_WORDS * 4) ? imem[instr_addr[7:2]] : `NOP_INSTR;
    assign dmem_rdata = dmem[dmem_req.addr[7:2]];  // combinational load path

    always @(negedge clk) begin
        if (arst_n && dmem_req.we) begin
            pending = dmem_req;
            store_log.push_back(dmem_req);
        end
    end

    always @(posedge clk) begin
        if (pending.we) begin
            dmem[pending.addr[7:2]] = pending.wdata;  // write lands on the strobe edge
            pending.we = 1'b0;
        end
    end

    // ==============================
    // stimulus helpers
    // ==============================

    // x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic word_t rand_imm();
        logic [31:0] bits;
        bits = rand_bits(12);
        return {{20{bits[11]}}, bits[11:0]};  // what addi sign-extends to
    endfunction

    function automatic word_t fill_word(word_t addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic word_t op_rr(funct7_t f7, funct3_t f3, int rd, int rs1, int rs2);
        return {f7, reg_addr_t'(rs2), reg_addr_t'(rs1), f3, reg_addr_t'(rd), OPC_OP};
    endfunction

    // I format: op-imm, load and jalr
    function automatic word_t op_imm(opcode_t opc, funct3_t f3, int rd, int rs1, word_t imm);
        return {imm[11:0], reg_addr_t'(rs1), f3, reg_addr_t'(rd), opc};
    endfunction

    function automatic word_t store_word(int rs2, int rs1, word_t imm);
        return {imm[11:5], reg_addr_t'(rs2), reg_addr_t'(rs1), F3_WORD, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t beq(int rs1, int rs2, word_t off);
        return {off[12], off[10:5], reg_addr_t'(rs2), reg_addr_t'(rs1), F3_BEQ,
                off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t jal(int rd, word_t off);
        return {off[20], off[10:1], off[11], off[19:12], reg_addr_t'(rd), OPC_JAL};
    endfunction

    task automatic emit(input word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        expect_q.push_back(dmem_req_t'{addr: addr, wdata: data, we: 1'b1});
    endtask

    task automatic new_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = `NOP_INSTR;  // everything past the program is a bubble
        end
        prog_len  = 0;
        test_errs = 0;
        expect_q.delete();
    endtask

    task automatic count_error();
        errors++;
        test_errs++;
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp)
            else begin
                $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
                count_error();
            end
    endtask

    // reset for 3 cycles, data memory refilled while the core is held
    task automatic reset_core();
        @(negedge clk);
        arst_n = 1'b0;
        @(negedge clk);
        store_log.delete();
        pending = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = fill_word(word_t'(i * 4));
        end
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        assert (halted === 1'b0)
            else begin
                $display("halted is high right after reset at %0t ns", $time);
                count_error();
            end
    endtask

    // latency counts cycles from the ecall fetch to halted
    task automatic run_to_halt(input word_t ecall_addr, output int latency);
        int fetched;
        fetched = -1;
        while (!halted) begin
            @(negedge clk);
            if (fetched < 0 && instr_addr == ecall_addr) begin
                fetched = cycle_cnt;
            end
        end
        latency = cycle_cnt - fetched;
    endtask

    task automatic check_log();
        assert (store_log.size() == expect_q.size())
            else begin
                $display("wrong number of stores at %0t ns: %0d logged, %0d expected",
                         $time, store_log.size(), expect_q.size());
                count_error();
            end
        for (int k = 0; k < store_log.size() && k < expect_q.size(); k++) begin
            check_word("dmem_req.addr", store_log[k].addr, expect_q[k].addr);
            check_word("dmem_req.wdata", store_log[k].wdata, expect_q[k].wdata);
        end
    endtask

    task automatic report_test(input string name);
        if (test_errs == 0) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", name, test_errs);
        end
    endtask

    task automatic run_program(input string name);
        word_t at;
        int    lat;
        at = word_t'(prog_len * 4);
        emit(ECALL);
        reset_core();
        run_to_halt(at, lat);
        check_word("halted latency", word_t'(lat), 32'd5);  // fetch to halted is 5 cycles
        check_log();
        report_test(name);
    endtask

    // ==============================
    // tests
    // ==============================
    task automatic arith_chain();
        word_t a;
        word_t b;
        word_t c;
        word_t res [10];
        new_program();
        a = rand_imm();
        b = rand_imm();
        c = rand_imm();
        emit(op_imm(OPC_OP_IMM, F3_ADD, 1, 0, a));
        emit(op_imm(OPC_OP_IMM, F3_ADD, 2, 0, b));
        emit(op_rr(F7_BASE, F3_ADD, 3, 1, 2));   // x2 from memory, x1 from writeback
        emit(op_rr(F7_SUB, F3_ADD, 4, 3, 1));    // x1 through the register bypass
        emit(op_rr(F7_BASE, F3_AND, 5, 4, 3));
        emit(op_rr(F7_BASE, F3_OR, 6, 5, 2));
        emit(op_rr(F7_BASE, F3_SLT, 7, 1, 2));
        emit(op_rr(F7_BASE, F3_SLTU, 8, 1, 2));
        emit(op_imm(OPC_OP_IMM, F3_ADD, 9, 6, c));
        res[3] = a + b;
        res[4] = res[3] - a;
        res[5] = res[4] & res[3];
        res[6] = res[5] | b;
        res[7] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        res[8] = (a < b) ? 32'd1 : 32'd0;
        res[9] = res[6] + c;
        for (int r = 9; r >= 3; r--) begin
            emit(store_word(r, 0, word_t'(r * 4)));  // first store data comes from memory stage
            expect_store(word_t'(r * 4), res[r]);
        end
        run_program("arith_chain");
    endtask

    task automatic load_use();
        word_t v;
        word_t w;
        new_program();
        v = rand_imm();
        w = rand_imm();
        emit(op_imm(OPC_OP_IMM, F3_ADD, 1, 0, v));
        emit(op_imm(OPC_OP_IMM, F3_ADD, 2, 0, w));
        emit(store_word(1, 0, 32'd32));
        emit(op_imm(OPC_LOAD, F3_WORD, 3, 0, 32'd32));
        emit(op_rr(F7_BASE, F3_ADD, 4, 3, 2));       // uses the load the very next cycle
        emit(store_word(4, 0, 32'd36));
        emit(op_imm(OPC_LOAD, F3_WORD, 5, 0, 32'd40)); // untouched word
        emit(store_word(5, 0, 32'd44));               // load forwarded as store data
        expect_store(32'd32, v);
        expect_store(32'd36, v + w);
        expect_store(32'd44, fill_word(32'd40));
        run_program("load_use");
    endtask

    task automatic beq_paths();
        word_t a;
        new_program();
        a = rand_imm();
        emit(op_imm(OPC_OP_IMM, F3_ADD, 1, 0, a));
        emit(op_imm(OPC_OP_IMM, F3_ADD, 2, 0, a));
        emit(op_imm(OPC_OP_IMM, F3_ADD, 3, 1, 32'd1));
        emit(beq(1, 3, 32'd12));          // not taken, would skip the next two stores
        emit(store_word(1, 0, 32'd64));
        emit(store_word(3, 0, 32'd68));
        emit(beq(1, 2, 32'd12));          // taken
        emit(store_word(3, 0, 32'd72));   // flushed slot
        emit(store_word(3, 0, 32'd76));   // flushed slot
        emit(store_word(2, 0, 32'd80));   // branch target
        expect_store(32'd64, a);
        expect_store(32'd68, a + 32'd1);
        expect_store(32'd80, a);
        run_program("beq_paths");
    endtask

    task automatic jal_jalr();
        word_t jal_at;
        word_t jalr_at;
        word_t land;
        new_program();
        land   = 32'd40;                  // jalr landing word, reached with bit 0 set
        jal_at = word_t'(prog_len * 4);
        emit(jal(1, 32'd16));
        emit(store_word(0, 0, 32'd100));
        emit(store_word(0, 0, 32'd104));
        emit(store_word(0, 0, 32'd108));  // skipped over
        emit(store_word(1, 0, 32'd112));
        emit(op_imm(OPC_OP_IMM, F3_ADD, 2, 0, land | 32'd1));
        jalr_at = word_t'(prog_len * 4);
        emit(op_imm(OPC_JALR, F3_JALR, 3, 2, 32'd0));  // base from the memory stage
        emit(store_word(0, 0, 32'd116));
        emit(store_word(0, 0, 32'd120));
        emit(store_word(0, 0, 32'd124));
        emit(store_word(3, 0, 32'd128));  // at land
        expect_store(32'd112, jal_at + 32'd4);
        expect_store(32'd128, jalr_at + 32'd4);
        run_program("jal_jalr");
    endtask

    task automatic x0_writes();
        word_t r;
        new_program();
        r = rand_imm() | 32'd1;           // never zero
        emit(op_imm(OPC_OP_IMM, F3_ADD, 1, 0, r));
        emit(op_imm(OPC_OP_IMM, F3_ADD, 0, 1, 32'd5));  // dropped write
        emit(op_rr(F7_BASE, F3_ADD, 2, 0, 1));          // x0 must not pick up the line above
        emit(store_word(0, 0, 32'd140));
        emit(store_word(2, 0, 32'd144));
        emit(op_imm(OPC_LOAD, F3_WORD, 0, 0, 32'd144)); // load into x0 dropped too
        emit(store_word(0, 0, 32'd148));
        expect_store(32'd140, 32'd0);
        expect_store(32'd144, r);
        expect_store(32'd148, 32'd0);
        run_program("x0_writes");
    endtask

    task automatic halt_timing();
        word_t r;
        word_t at;
        int    lat;
        new_program();
        r = rand_imm();
        emit(op_imm(OPC_OP_IMM, F3_ADD, 1, 0, r));
        emit(store_word(1, 0, 32'd160));
        at = word_t'(prog_len * 4);
        emit(ECALL);
        emit(`NOP_INSTR);
        emit(`NOP_INSTR);
        emit(store_word(1, 0, 32'd164));  // strobes one cycle after halted
        expect_store(32'd160, r);
        reset_core();
        run_to_halt(at, lat);
        check_word("halted latency", word_t'(lat), 32'd5);
        check_log();
        repeat (10) begin
            @(negedge clk);
            assert (halted === 1'b1)
                else begin
                    $display("halted dropped without a reset at %0t ns", $time);
                    count_error();
                end
        end
        report_test("halt_timing");
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        arst_n       = 1'b0;
        lfsr         = 32'hce71_a54e;
        cycle_cnt    = 0;
        errors       = 0;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        pending      = '0;
        new_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = fill_word(word_t'(i * 4));
        end
        arith_chain();
        load_use();
        beq_paths();
        jal_jalr();
        x0_writes();
        halt_timing();
        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 NUM_TESTS, tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/riscv_core.sv ====
// top level of the five stage pipeline, the testbench attaches instruction and data memories
`timescale 1ns/1ns
`default_nettype none

module riscv_core (
    input  logic                clk,
    input  logic                arst_n,
    output isa_pkg::word_t      instr_addr,
    input  isa_pkg::word_t      instr,
    output pipe_pkg::dmem_req_t dmem_req,
    input  isa_pkg::word_t      dmem_rdata,
    output logic                halted
);

    import isa_pkg::*;
    import pipe_pkg::*;

    fd_t       fd;        // IF/ID contents
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    ctrl_t     ctrl;
    word_t     rs1_data;
    word_t     rs2_data;
    de_t       de;        // decode output into ID/EX
    em_t       em;
    redirect_t redirect;  // execute back to fetch
    fwd_t      fwd;       // memory and writeback into execute
    wb_t       wb;

    // ==============================
    // fetch and decode
    // ==============================
    fetch_stage fetch_stage_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .redirect   (redirect),
        .instr      (instr),
        .instr_addr (instr_addr),
        .fd         (fd)
    );

    decoder decoder_inst (
        .fd   (fd),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .imm  (imm),
        .ctrl (ctrl)
    );

    reg_file reg_file_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    assign de = '{ctrl: ctrl, rs1_data: rs1_data, rs2_data: rs2_data, imm: imm,
                  rd: rd, rs1: rs1, rs2: rs2, pc: fd.pc};

    // ==============================
    // execute, memory, writeback
    // ==============================
    execute_stage execute_stage_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .de       (de),
        .fwd      (fwd),
        .redirect (redirect),
        .em       (em)
    );

    mem_wb_stage mem_wb_stage_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .em         (em),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .fwd        (fwd),
        .wb         (wb),
        .halted     (halted)
    );

endmodule

`default_nettype wire

// ==== hdl/mem_wb_stage.sv ====
// memory and writeback stages with the data port, the destination bus and the halt flag
`timescale 1ns/1ns
`default_nettype none

module mem_wb_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  pipe_pkg::em_t       em,
    output pipe_pkg::dmem_req_t dmem_req,
    input  isa_pkg::word_t      dmem_rdata,
    output pipe_pkg::fwd_t      fwd,
    output pipe_pkg::wb_t       wb,
    output logic                halted
);

    import isa_pkg::*;
    import pipe_pkg::*;

    em_t   mem_q;   // EX/MEM
    word_t m_data;  // destination bus in the memory stage
    wb_t   wb_q;    // MEM/WB
    logic  halt_q;  // ecall in writeback

    // ==============================
    // memory stage
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_q <= '0;
        end else begin
            mem_q <= em;
        end
    end

    assign dmem_req = '{addr:  mem_q.alu_result,
                        wdata: mem_q.store_data,
                        we:    mem_q.ctrl.mem_we};  // strobe lasts the one cycle here

    always_comb begin
        case (mem_q.ctrl.wb_sel)
            WB_MEM:  m_data = dmem_rdata;   // load data forwarded with no stall
            WB_PC4:  m_data = mem_q.pc_plus4;
            default: m_data = mem_q.alu_result;
        endcase
    end

    // ==============================
    // writeback stage
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_q   <= '0;
            halt_q <= 1'b0;
        end else begin
            wb_q   <= '{we: mem_q.ctrl.reg_we, rd: mem_q.rd, data: m_data};
            halt_q <= mem_q.ctrl.halt;
        end
    end

    assign wb  = wb_q;
    assign fwd = '{m_we: mem_q.ctrl.reg_we, m_rd: mem_q.rd, m_data: m_data,
                   w_we: wb_q.we,           w_rd: wb_q.rd,  w_data: wb_q.data};

    // sticky until reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted <= 1'b0;
        end else if (halt_q) begin
            halted <= 1'b1;
        end
    end

    a_store_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_req.we |-> dmem_req.addr[1:0] == 2'b00)
        else $error("store to unaligned address %h", dmem_req.addr);

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
// execute stage with the ID/EX register, forwarding, the ALU and branch resolution
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  pipe_pkg::de_t       de,
    input  pipe_pkg::fwd_t      fwd,
    output pipe_pkg::redirect_t redirect,
    output pipe_pkg::em_t       em
);

    import isa_pkg::*;
    import pipe_pkg::*;

    de_t   ex_q;        // ID/EX
    word_t rs1_val;     // forwarded operands
    word_t rs2_val;
    word_t op_b;
    word_t alu_result;
    word_t pc_plus4;
    word_t br_target;   // pc + imm for beq and jal
    logic  beq_eq;

    // memory stage is younger so it wins over writeback
    function automatic word_t forward(reg_addr_t rs, word_t reg_val, fwd_t f);
        if (f.m_we && f.m_rd == rs) begin
            return f.m_data;
        end
        if (f.w_we && f.w_rd == rs) begin
            return f.w_data;
        end
        return reg_val;
    endfunction

    // ==============================
    // ID/EX register
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_q <= '0;
        end else if (redirect.taken) begin
            ex_q <= '0;  // instruction in decode is on the wrong path
        end else begin
            ex_q <= de;
        end
    end

    assign rs1_val = forward(ex_q.rs1, ex_q.rs1_data, fwd);
    assign rs2_val = forward(ex_q.rs2, ex_q.rs2_data, fwd);
    assign op_b    = ex_q.ctrl.use_imm ? ex_q.imm : rs2_val;

    // ==============================
    // ALU
    // ==============================
    always_comb begin
        case (ex_q.ctrl.alu_op)
            ALU_ADD:  alu_result = rs1_val + op_b;
            ALU_SUB:  alu_result = rs1_val - op_b;
            ALU_AND:  alu_result = rs1_val & op_b;
            ALU_OR:   alu_result = rs1_val | op_b;
            ALU_SLT:  alu_result = word_t'($signed(rs1_val) < $signed(op_b));
            ALU_SLTU: alu_result = word_t'(rs1_val < op_b);
            default:  alu_result = rs1_val + op_b;
        endcase
    end

    // branch and jump resolution
    assign beq_eq    = (rs1_val == rs2_val);
    assign br_target = ex_q.pc + ex_q.imm;
    assign pc_plus4  = ex_q.pc + word_t'(4);

    assign redirect.taken  = (ex_q.ctrl.branch && beq_eq) || ex_q.ctrl.jump;
    assign redirect.target = ex_q.ctrl.jalr ? {alu_result[$bits(word_t)-1:1], 1'b0}
                                            : br_target;

    assign em = '{ctrl:       ex_q.ctrl,
                  alu_result: alu_result,
                  store_data: rs2_val,    // sw data needs forwarding too
                  rd:         ex_q.rd,
                  pc_plus4:   pc_plus4};

    // the second wrong-path slot arrives as a NOP from fetch and must not redirect
    a_no_double_redirect: assert property (@(posedge clk) disable iff (!arst_n)
        redirect.taken |-> ##2 !redirect.taken)
        else $error("redirect taken from a flushed slot");

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
// 32 entry register file with a writeback to decode bypass, read in decode and written in writeback
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module reg_file (
    input  logic               clk,
    input  logic               arst_n,
    input  isa_pkg::reg_addr_t rs1,
    input  isa_pkg::reg_addr_t rs2,
    output isa_pkg::word_t     rs1_data,
    output isa_pkg::word_t     rs2_data,
    input  pipe_pkg::wb_t      wb
);

    import isa_pkg::*;

    word_t regs [`NUM_REGS];  // entry 0 is never written

    // x0 first, then the value being written this cycle, then the array
    assign rs1_data = (rs1 == '0)               ? '0      :
                      (wb.we && wb.rd == rs1)   ? wb.data : regs[rs1];
    assign rs2_data = (rs2 == '0)               ? '0      :
                      (wb.we && wb.rd == rs2)   ? wb.data : regs[rs2];

    always_ff @(posedge clk) begin
        if (wb.we) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // reg_we for rd x0 is dropped in the decoder three stages earlier
    a_no_x0_write: assert property (@(posedge clk) disable iff (!arst_n) wb.we |-> wb.rd != '0)
        else $error("register write aimed at x0");

endmodule

`default_nettype wire

// ==== hdl/decoder.sv ====
// hard-wired decoder for register fields, immediates and the control bundle, used in decode
`timescale 1ns/1ns
`default_nettype none

module decoder (
    input  pipe_pkg::fd_t        fd,
    output isa_pkg::reg_addr_t   rs1,
    output isa_pkg::reg_addr_t   rs2,
    output isa_pkg::reg_addr_t   rd,
    output isa_pkg::word_t       imm,
    output pipe_pkg::ctrl_t      ctrl
);

    import isa_pkg::*;
    import pipe_pkg::*;

    word_t   ins;
    opcode_t opcode;
    funct3_t f3;
    funct7_t f7;

    assign ins    = fd.instr;
    assign opcode = ins[6:0];
    assign f3     = ins[14:12];
    assign f7     = ins[31:25];

    // fields sit at fixed positions in every format
    assign rs1 = ins[19:15];
    assign rs2 = ins[24:20];
    assign rd  = ins[11:7];

    // ==============================
    // immediates
    // ==============================
    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_LOAD, OPC_JALR:
                imm = word_t'($signed(ins[31:20]));                                // I
            OPC_STORE:
                imm = word_t'($signed({ins[31:25], ins[11:7]}));                   // S
            OPC_BRANCH:
                imm = word_t'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
            OPC_JAL:
                imm = word_t'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
            default:
                imm = '0;
        endcase
    end

    // ==============================
    // control bundle
    // ==============================
    always_comb begin
        ctrl = '0;  // anything unrecognised stays a bubble
        case (opcode)
            OPC_OP: begin
                ctrl.wb_sel = WB_ALU;
                ctrl.reg_we = 1'b1;
                if (f7 == F7_SUB && f3 == F3_ADD) begin
                    ctrl.alu_op = ALU_SUB;
                end else if (f7 != F7_BASE) begin
                    ctrl.reg_we = 1'b0;  // no mul group here
                end else begin
                    case (f3)
                        F3_ADD:  ctrl.alu_op = ALU_ADD;
                        F3_SLT:  ctrl.alu_op = ALU_SLT;
                        F3_SLTU: ctrl.alu_op = ALU_SLTU;
                        F3_OR:   ctrl.alu_op = ALU_OR;
                        F3_AND:  ctrl.alu_op = ALU_AND;
                        default: ctrl.reg_we = 1'b0;  // shifts and xor unsupported
                    endcase
                end
            end
            OPC_OP_IMM: begin
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
                case (f3)
                    F3_ADD:  ctrl.alu_op = ALU_ADD;
                    F3_SLT:  ctrl.alu_op = ALU_SLT;
                    F3_SLTU: ctrl.alu_op = ALU_SLTU;
                    F3_OR:   ctrl.alu_op = ALU_OR;
                    F3_AND:  ctrl.alu_op = ALU_AND;
                    default: ctrl = '0;
                endcase
            end
            OPC_LOAD: if (f3 == F3_WORD) begin
                ctrl.use_imm = 1'b1;    // address is rs1 + imm
                ctrl.wb_sel  = WB_MEM;
                ctrl.reg_we  = 1'b1;
            end
            OPC_STORE: if (f3 == F3_WORD) begin
                ctrl.use_imm = 1'b1;
                ctrl.mem_we  = 1'b1;
            end
            OPC_BRANCH: if (f3 == F3_BEQ) begin
                ctrl.branch = 1'b1;     // compare done on forwarded operands
            end
            OPC_JAL: begin
                ctrl.jump   = 1'b1;
                ctrl.wb_sel = WB_PC4;
                ctrl.reg_we = 1'b1;
            end
            OPC_JALR: if (f3 == F3_JALR) begin
                ctrl.jump    = 1'b1;
                ctrl.jalr    = 1'b1;
                ctrl.use_imm = 1'b1;    // alu forms rs1 + imm
                ctrl.wb_sel  = WB_PC4;
                ctrl.reg_we  = 1'b1;
            end
            OPC_SYSTEM: if (ins[31:7] == '0) begin
                ctrl.halt = 1'b1;       // ecall
            end
            default: ctrl = '0;
        endcase
        if (rd == '0) begin
            ctrl.reg_we = 1'b0;         // the only x0 check in the pipeline
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
// fetch stage with the PC register and the IF/ID register, instantiated by the core top level
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module fetch_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  pipe_pkg::redirect_t redirect,
    input  isa_pkg::word_t      instr,
    output isa_pkg::word_t      instr_addr,
    output pipe_pkg::fd_t       fd
);

    import isa_pkg::*;
    import pipe_pkg::*;

    word_t pc;       // address fetched this cycle
    word_t pc_next;

    assign pc_next    = redirect.taken ? redirect.target : pc + word_t'(4);
    assign instr_addr = pc;  // instruction comes back in the same cycle

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // ==============================
    // IF/ID register
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fd <= FD_BUBBLE;
        end else begin
            fd.instr <= redirect.taken ? `NOP_INSTR : instr;  // wrong-path fetch dies here
            fd.pc    <= pc;
        end
    end

    // targets come from execute so this also covers the redirect path
    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
        else $error("pc not word aligned %h", pc);

endmodule

`default_nettype wire

// ==== hdl/pipe_pkg.sv ====
// pipeline bundles passed between the stages and to the data port, imported by the stages
`default_nettype none
`include "cpu_consts.svh"

package pipe_pkg;

    import isa_pkg::*;

    // source of the register write
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    // ==============================
    // control bundle
    // ==============================
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;  // operand b from the immediate
        logic    branch;   // beq
        logic    jump;     // jal or jalr
        logic    jalr;     // target from the alu sum
        logic    mem_we;   // store
        wb_sel_e wb_sel;
        logic    reg_we;   // already low for rd x0
        logic    halt;     // ecall
    } ctrl_t;

    // ==============================
    // stage registers
    // ==============================
    typedef struct packed {
        word_t instr;
        word_t pc;
    } fd_t;

    localparam fd_t FD_BUBBLE = '{instr: `NOP_INSTR, pc: `RESET_PC};  // IF/ID after reset

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rs1_data;  // register file value, wb bypass included
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rd;
        reg_addr_t rs1;       // kept for forwarding compares
        reg_addr_t rs2;
        word_t     pc;
    } de_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     alu_result;  // also the data address
        word_t     store_data;
        reg_addr_t rd;
        word_t     pc_plus4;    // link value
    } em_t;

    // ==============================
    // side paths
    // ==============================
    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic      m_we;
        reg_addr_t m_rd;
        word_t     m_data;  // memory stage value
        logic      w_we;
        reg_addr_t w_rd;
        word_t     w_data;  // writeback value
    } fwd_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;     // one cycle strobe per store
    } dmem_req_t;

endpackage

`default_nettype wire

// ==== hdl/isa_pkg.sv ====
// instruction set types and encodings, imported by the decoder and the datapath stages
`default_nettype none
`include "cpu_consts.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0]             word_t;      // data, address or instruction
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_addr_t;  // register index
    typedef logic [6:0]                   opcode_t;    // instr[6:0]
    typedef logic [2:0]                   funct3_t;    // instr[14:12]
    typedef logic [6:0]                   funct7_t;    // instr[31:25]

    // ==============================
    // major opcodes
    // ==============================
    localparam opcode_t OPC_OP     = 7'b011_0011;  // register-register alu
    localparam opcode_t OPC_OP_IMM = 7'b001_0011;  // register-immediate alu
    localparam opcode_t OPC_LOAD   = 7'b000_0011;
    localparam opcode_t OPC_STORE  = 7'b010_0011;
    localparam opcode_t OPC_BRANCH = 7'b110_0011;
    localparam opcode_t OPC_JAL    = 7'b110_1111;
    localparam opcode_t OPC_JALR   = 7'b110_0111;
    localparam opcode_t OPC_SYSTEM = 7'b111_0011;  // ecall only

    // funct3 values of the supported subset
    localparam funct3_t F3_ADD  = 3'b000;  // add sub addi
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;
    localparam funct3_t F3_WORD = 3'b010;  // lw and sw
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_JALR = 3'b000;

    localparam funct7_t F7_BASE = 7'b000_0000;
    localparam funct7_t F7_SUB  = 7'b010_0000;  // sub in the OP group

    // alu operation, ADD is zero so a cleared bundle adds
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

endpackage

`default_nettype wire

// ==== include/cpu_consts.svh ====
// core width and encoding constants, included by the packages and by RTL that needs a value
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// ==============================
// datapath sizes
// ==============================
`define XLEN      32              // data and address width
`define NUM_REGS  32              // architectural registers x0..x31

// ==============================
// fixed encodings
// ==============================

// the pipeline bubble is a real instruction that writes nothing
`define NOP_INSTR 32'h0000_0013   // addi x0, x0, 0
`define RESET_PC  32'h0000_0000   // first fetch address out of reset

`endif
